// ==== butterfly_pkg.sv ====
`default_nettype none

package butterfly_pkg;

  // ======================================================================
  // sizes
  // ======================================================================

  // sample width and fixed-point position
  localparam int DATA_W = 16;
  localparam int FRAC_W = 8;

  // butterflies carried by one transaction
  localparam int NUM_LANES = 4;
  localparam int LANE_W = $clog2(NUM_LANES);
  localparam int LAST_LANE = NUM_LANES - 1;

  // one extra bit for a sum of two samples
  localparam int SUM_W = DATA_W + 1;
  // full product of a sample and a sum, plus headroom for k1 - k3
  localparam int PROD_W = 2 * DATA_W + 2;

  // ======================================================================
  // types
  // ======================================================================

  // signed two's complement fixed point
  typedef logic signed [DATA_W-1:0] sample_t;

  typedef logic [LANE_W-1:0] lane_idx_t;

  // one butterfly worth of inputs
  typedef struct packed {
    sample_t ar;
    sample_t ac;
    sample_t br;
    sample_t bc;
    sample_t wr;
    sample_t wc;
  } operand_t;

  // c = a + w*b, d = a - w*b
  typedef struct packed {
    sample_t cr;
    sample_t cc;
    sample_t dr;
    sample_t dc;
  } result_t;

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_COMP = 2'd1,
    ST_DONE = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== complex_multiplier.sv ====
`default_nettype none

// three-multiplier complex product, purely combinational
// p = x * y with x = xr + j*xi and y = yr + j*yi
module complex_multiplier (
  input  butterfly_pkg::sample_t xr,
  input  butterfly_pkg::sample_t xi,
  input  butterfly_pkg::sample_t yr,
  input  butterfly_pkg::sample_t yi,
  output butterfly_pkg::sample_t pr,
  output butterfly_pkg::sample_t pi
);

  // pre-adders, one bit wider than a sample
  logic signed [butterfly_pkg::SUM_W-1:0] sum_x;
  logic signed [butterfly_pkg::SUM_W-1:0] dif_y;
  logic signed [butterfly_pkg::SUM_W-1:0] sum_y;

  // the three partial products
  logic signed [butterfly_pkg::PROD_W-1:0] k1;
  logic signed [butterfly_pkg::PROD_W-1:0] k2;
  logic signed [butterfly_pkg::PROD_W-1:0] k3;

  // full precision real and imaginary parts
  logic signed [butterfly_pkg::PROD_W-1:0] re_full;
  logic signed [butterfly_pkg::PROD_W-1:0] im_full;

  // rescaled back to the sample grid
  logic signed [butterfly_pkg::PROD_W-1:0] re_shift;
  logic signed [butterfly_pkg::PROD_W-1:0] im_shift;

  // all operands signed so every term sign-extends to its target width
  assign sum_x = xr + xi;
  assign dif_y = yi - yr;
  assign sum_y = yr + yi;

  // k1 = yr*(xr+xi)
  assign k1 = yr * sum_x;
  // k2 = xr*(yi-yr)
  assign k2 = xr * dif_y;
  // k3 = xi*(yr+yi)
  assign k3 = xi * sum_y;

  // re = xr*yr - xi*yi, im = xr*yi + xi*yr
  assign re_full = k1 - k3;
  assign im_full = k1 + k2;

  // arithmetic shift truncates toward minus infinity
  assign re_shift = re_full >>> butterfly_pkg::FRAC_W;
  assign im_shift = im_full >>> butterfly_pkg::FRAC_W;

  // keep the low sample bits, upper bits simply wrap away
  assign pr = re_shift[butterfly_pkg::DATA_W-1:0];
  assign pi = im_shift[butterfly_pkg::DATA_W-1:0];

endmodule

`default_nettype wire

// ==== lane_counter.sv ====
`default_nettype none

// index of the lane currently in the shared multiplier
module lane_counter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     clear,
  input  logic                     advance,
  output butterfly_pkg::lane_idx_t lane_idx,
  output logic                     lane_last
);

  // the only place the index is compared against the final lane
  assign lane_last = (lane_idx == butterfly_pkg::lane_idx_t'(butterfly_pkg::LAST_LANE));

  always_ff @(posedge clk) begin
    if (reset) begin
      lane_idx <= '0;
    end else if (clear) begin
      lane_idx <= '0;
    end else if (advance) begin
      // wrap explicitly, lane count need not be a power of two
      if (lane_last) begin
        lane_idx <= '0;
      end else begin
        lane_idx <= lane_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== butterfly_controller.sv ====
`default_nettype none

// idle / compute / done sequencing around the shared multiplier
module butterfly_controller (
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  input  logic send_rdy,
  input  logic lane_last,
  output logic recv_rdy,
  output logic send_val,
  output logic accept,
  output logic lane_advance
);

  butterfly_pkg::ctrl_state_t state;
  butterfly_pkg::ctrl_state_t state_next;

  // ======================================================================
  // state register
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= butterfly_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ======================================================================
  // next state
  // ======================================================================

  always_comb begin
    state_next = state;
    case (state)
      butterfly_pkg::ST_IDLE: begin
        // operands latched on this edge
        if (recv_val) begin
          state_next = butterfly_pkg::ST_COMP;
        end
      end
      butterfly_pkg::ST_COMP: begin
        // last lane is written on the edge that leaves this state
        if (lane_last) begin
          state_next = butterfly_pkg::ST_DONE;
        end
      end
      butterfly_pkg::ST_DONE: begin
        // hold results until the sink takes them
        if (send_rdy) begin
          state_next = butterfly_pkg::ST_IDLE;
        end
      end
      default: begin
        state_next = butterfly_pkg::ST_IDLE;
      end
    endcase
  end

  // ======================================================================
  // outputs
  // ======================================================================

  // one transaction in flight, so only idle may take new input
  assign recv_rdy = (state == butterfly_pkg::ST_IDLE);
  assign send_val = (state == butterfly_pkg::ST_DONE);

  // load pulse for the operand bank and counter clear
  assign accept = recv_val && recv_rdy;

  // one lane per cycle while computing
  assign lane_advance = (state == butterfly_pkg::ST_COMP);

endmodule

`default_nettype wire

// ==== lane_bank.sv ====
`default_nettype none

// one register per lane with its own write enable
// payload type is set per instance
module lane_bank #(
  parameter type entry_t = butterfly_pkg::operand_t
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   entry_we  [butterfly_pkg::NUM_LANES],
  input  entry_t entry_in  [butterfly_pkg::NUM_LANES],
  output entry_t entry_out [butterfly_pkg::NUM_LANES]
);

  // storage
  entry_t entry_q [butterfly_pkg::NUM_LANES];

  // ======================================================================
  // per-entry registers
  // ======================================================================

  for (genvar i = 0; i < butterfly_pkg::NUM_LANES; i++) begin : g_entry

    always_ff @(posedge clk) begin
      if (reset) begin
        // bank reads as zero straight after reset
        entry_q[i] <= '0;
      end else if (entry_we[i]) begin
        entry_q[i] <= entry_in[i];
      end
    end

    // registered view, no bypass from the write port
    assign entry_out[i] = entry_q[i];

  end

endmodule

`default_nettype wire

// ==== butterfly_datapath.sv ====
`default_nettype none

// one butterfly per cycle for the selected lane
module butterfly_datapath (
  input  butterfly_pkg::lane_idx_t lane_idx,
  input  butterfly_pkg::operand_t  operands [butterfly_pkg::NUM_LANES],
  output butterfly_pkg::result_t   result
);

  // current lane operands
  butterfly_pkg::operand_t sel;

  // w*b
  butterfly_pkg::sample_t prod_r;
  butterfly_pkg::sample_t prod_i;

  // ======================================================================
  // lane select
  // ======================================================================

  assign sel = operands[lane_idx];

  // ======================================================================
  // twiddle multiply
  // ======================================================================

  // x is the b operand, y is the twiddle
  complex_multiplier mult0 (
    .xr(sel.br),
    .xi(sel.bc),
    .yr(sel.wr),
    .yi(sel.wc),
    .pr(prod_r),
    .pi(prod_i)
  );

  // ======================================================================
  // sum and difference
  // ======================================================================

  // all sample wide, so overflow wraps mod 2^DATA_W
  always_comb begin
    result.cr = sel.ar + prod_r;
    result.cc = sel.ac + prod_i;
    result.dr = sel.ar - prod_r;
    result.dc = sel.ac - prod_i;
  end

endmodule

`default_nettype wire

// ==== multi_butterfly.sv ====
`default_nettype none

// buffered multi-lane radix-2 butterfly
// lanes are computed one per cycle through a single multiplier
module multi_butterfly (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   recv_val,
  output logic                   recv_rdy,
  output logic                   send_val,
  input  logic                   send_rdy,

  input  butterfly_pkg::sample_t ar [butterfly_pkg::NUM_LANES],
  input  butterfly_pkg::sample_t ac [butterfly_pkg::NUM_LANES],
  input  butterfly_pkg::sample_t br [butterfly_pkg::NUM_LANES],
  input  butterfly_pkg::sample_t bc [butterfly_pkg::NUM_LANES],
  input  butterfly_pkg::sample_t wr [butterfly_pkg::NUM_LANES],
  input  butterfly_pkg::sample_t wc [butterfly_pkg::NUM_LANES],

  output butterfly_pkg::sample_t cr [butterfly_pkg::NUM_LANES],
  output butterfly_pkg::sample_t cc [butterfly_pkg::NUM_LANES],
  output butterfly_pkg::sample_t dr [butterfly_pkg::NUM_LANES],
  output butterfly_pkg::sample_t dc [butterfly_pkg::NUM_LANES]
);

  // control
  logic                     accept;
  logic                     lane_advance;
  logic                     lane_last;
  butterfly_pkg::lane_idx_t lane_idx;

  // operand storage
  logic                    operand_we  [butterfly_pkg::NUM_LANES];
  butterfly_pkg::operand_t operand_in  [butterfly_pkg::NUM_LANES];
  butterfly_pkg::operand_t operand_out [butterfly_pkg::NUM_LANES];

  // result storage
  butterfly_pkg::result_t lane_result;
  logic                   result_we  [butterfly_pkg::NUM_LANES];
  butterfly_pkg::result_t result_in  [butterfly_pkg::NUM_LANES];
  butterfly_pkg::result_t result_out [butterfly_pkg::NUM_LANES];

  // ======================================================================
  // sequencing
  // ======================================================================

  butterfly_controller ctrl0 (
    .clk(clk),
    .reset(reset),
    .recv_val(recv_val),
    .send_rdy(send_rdy),
    .lane_last(lane_last),
    .recv_rdy(recv_rdy),
    .send_val(send_val),
    .accept(accept),
    .lane_advance(lane_advance)
  );

  // cleared on accept so lane 0 is first in compute
  lane_counter cnt0 (
    .clk(clk),
    .reset(reset),
    .clear(accept),
    .advance(lane_advance),
    .lane_idx(lane_idx),
    .lane_last(lane_last)
  );

  // ======================================================================
  // per-lane packing, write decode and unpacking
  // ======================================================================

  for (genvar i = 0; i < butterfly_pkg::NUM_LANES; i++) begin : g_lane
    // whole transaction captured at once
    assign operand_we[i] = accept;
    assign operand_in[i] = '{ar: ar[i], ac: ac[i], br: br[i],
                             bc: bc[i], wr: wr[i], wc: wc[i]};

    // one-hot on the lane being computed
    assign result_we[i] = lane_advance &&
                          (lane_idx == butterfly_pkg::lane_idx_t'(i));
    // every entry sees the same result, enables pick the target
    assign result_in[i] = lane_result;

    // results held steady through done
    assign cr[i] = result_out[i].cr;
    assign cc[i] = result_out[i].cc;
    assign dr[i] = result_out[i].dr;
    assign dc[i] = result_out[i].dc;
  end

  // ======================================================================
  // storage and datapath
  // ======================================================================

  lane_bank #(.entry_t(butterfly_pkg::operand_t)) operand_bank (
    .clk(clk),
    .reset(reset),
    .entry_we(operand_we),
    .entry_in(operand_in),
    .entry_out(operand_out)
  );

  butterfly_datapath dp0 (
    .lane_idx(lane_idx),
    .operands(operand_out),
    .result(lane_result)
  );

  lane_bank #(.entry_t(butterfly_pkg::result_t)) result_bank (
    .clk(clk),
    .reset(reset),
    .entry_we(result_we),
    .entry_in(result_in),
    .entry_out(result_out)
  );

endmodule

`default_nettype wire

// ==== tb_butterfly_model.svh ====
`ifndef TB_BUTTERFLY_MODEL_SVH
`define TB_BUTTERFLY_MODEL_SVH

// ======================================================================
// reference butterfly and compare tasks
// ======================================================================

// running totals for the closing line
int error_count = 0;
int check_count = 0;

// straight four-multiplier form, no sharing of partial products
function automatic butterfly_pkg::result_t ref_butterfly(input butterfly_pkg::operand_t op);
  longint                 re_full;
  longint                 im_full;
  butterfly_pkg::sample_t pr;
  butterfly_pkg::sample_t pi;
  butterfly_pkg::result_t res;
  // w*b at full precision
  re_full = longint'(op.br) * longint'(op.wr) - longint'(op.bc) * longint'(op.wc);
  im_full = longint'(op.br) * longint'(op.wc) + longint'(op.bc) * longint'(op.wr);
  // floor after the rescale, then keep the low sample bits
  pr = butterfly_pkg::sample_t'(re_full >>> butterfly_pkg::FRAC_W);
  pi = butterfly_pkg::sample_t'(im_full >>> butterfly_pkg::FRAC_W);
  // sample wide sums wrap on their own
  res.cr = op.ar + pr;
  res.cc = op.ac + pi;
  res.dr = op.ar - pr;
  res.dc = op.ac - pi;
  return res;
endfunction

// one output field of one lane
task automatic compare_sample(input string name, input int lane,
                              input butterfly_pkg::sample_t expected,
                              input butterfly_pkg::sample_t actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("FAIL t=%0t %s[%0d] expected %0d actual %0d",
             $time, name, lane, expected, actual);
  end
endtask

// all four fields of a lane result
task automatic check_result(input int lane, input butterfly_pkg::result_t expected,
                            input butterfly_pkg::result_t actual);
  compare_sample("cr", lane, expected.cr, actual.cr);
  compare_sample("cc", lane, expected.cc, actual.cc);
  compare_sample("dr", lane, expected.dr, actual.dr);
  compare_sample("dc", lane, expected.dc, actual.dc);
endtask

// handshake outputs
task automatic check_flag(input string name, input logic expected, input logic actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("FAIL t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
  end
endtask

`endif

// ==== tb_multi_butterfly.sv ====
`default_nettype none

module tb_multi_butterfly;

  localparam int NUM_DIRECTED = 4;
  localparam int NUM_RANDOM = 200;
  localparam int NUM_B2B = 24;
  localparam int TXN_TOTAL = NUM_DIRECTED + NUM_RANDOM + NUM_B2B;
  localparam int MAX_STALL = 7;
  // accept edge to the first edge that samples send_val high
  localparam int LATENCY = butterfly_pkg::NUM_LANES + 1;
  localparam int TIMEOUT_CYCLES =
    TXN_TOTAL * (butterfly_pkg::NUM_LANES + 2 + MAX_STALL) + 16 + 100;

  logic clk;
  logic reset;
  logic recv_val;
  logic recv_rdy;
  logic send_val;
  logic send_rdy;
  butterfly_pkg::sample_t ar [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t ac [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t br [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t bc [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t wr [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t wc [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t cr [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t cc [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t dr [butterfly_pkg::NUM_LANES];
  butterfly_pkg::sample_t dc [butterfly_pkg::NUM_LANES];

  int seed = 32'h7332_9599;
  // next transaction to present and the sink stall of each transaction
  butterfly_pkg::operand_t txn_ops [butterfly_pkg::NUM_LANES];
  int stall_len [TXN_TOTAL];

  // checker model of the handshake
  butterfly_pkg::result_t exp_q [$];
  butterfly_pkg::result_t first_res [butterfly_pkg::NUM_LANES];
  logic busy = 1'b0;
  logic have_first = 1'b0;
  int   acc_cyc = 0;
  int   cyc = 0;
  int   accept_count = 0;
  int   done_count = 0;

  // sink and watchdog state
  int   stall_left = 0;
  int   stall_idx = 0;
  logic in_done = 1'b0;
  int   wd_cycles = 0;

  `include "tb_butterfly_model.svh"

  multi_butterfly dut0 (
    .clk(clk), .reset(reset),
    .recv_val(recv_val), .recv_rdy(recv_rdy),
    .send_val(send_val), .send_rdy(send_rdy),
    .ar(ar), .ac(ac), .br(br), .bc(bc), .wr(wr), .wc(wc),
    .cr(cr), .cc(cc), .dr(dr), .dc(dc)
  );

  always #50 clk = ~clk;

  // ======================================================================
  // helpers
  // ======================================================================

  function automatic butterfly_pkg::operand_t lane_inputs(input int i);
    return '{ar: ar[i], ac: ac[i], br: br[i], bc: bc[i], wr: wr[i], wc: wc[i]};
  endfunction

  function automatic butterfly_pkg::result_t lane_outputs(input int i);
    return '{cr: cr[i], cc: cc[i], dr: dr[i], dc: dc[i]};
  endfunction

  task automatic set_lane(input int lane, input int a_r, input int a_c, input int b_r,
                          input int b_c, input int w_r, input int w_c);
    txn_ops[lane].ar = butterfly_pkg::sample_t'(a_r);
    txn_ops[lane].ac = butterfly_pkg::sample_t'(a_c);
    txn_ops[lane].br = butterfly_pkg::sample_t'(b_r);
    txn_ops[lane].bc = butterfly_pkg::sample_t'(b_c);
    txn_ops[lane].wr = butterfly_pkg::sample_t'(w_r);
    txn_ops[lane].wc = butterfly_pkg::sample_t'(w_c);
  endtask

  task automatic fill_random_lanes();
    for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
      set_lane(i, $random(seed), $random(seed), $random(seed),
               $random(seed), $random(seed), $random(seed));
    end
  endtask

  // staged lanes onto the DUT input pins
  task automatic apply_operands();
    for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
      ar[i] = txn_ops[i].ar;
      ac[i] = txn_ops[i].ac;
      br[i] = txn_ops[i].br;
      bc[i] = txn_ops[i].bc;
      wr[i] = txn_ops[i].wr;
      wc[i] = txn_ops[i].wc;
    end
  endtask

  // starts on a falling edge and returns on the falling edge after the accept
  task automatic present_txn(input logic hold_val);
    apply_operands();
    recv_val = 1'b1;
    // recv_rdy only moves on a rising edge
    while (!recv_rdy) @(negedge clk);
    @(negedge clk);
    if (!hold_val) recv_val = 1'b0;
  endtask

  // ======================================================================
  // stimulus
  // ======================================================================

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
      set_lane(i, 0, 0, 0, 0, 0, 0);
    end
    apply_operands();
    for (int t = 0; t < TXN_TOTAL; t++) begin
      stall_len[t] = $unsigned($random(seed)) % (MAX_STALL + 1);
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    // idle straight out of reset
    check_flag("recv_rdy", 1'b1, recv_rdy);
    check_flag("send_val", 1'b0, send_val);

    // w = 1.0 gives c = a + b and d = a - b
    for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
      set_lane(i, 100 * i - 150, 40 - 30 * i, 1000 - 333 * i, 250 * i - 700, 256, 0);
    end
    present_txn(1'b0);
    // w = j rotates b by a quarter turn
    for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
      set_lane(i, 2000 - 900 * i, 512 * i - 64, 300 + 45 * i, 610 * i - 1200, 0, 256);
    end
    present_txn(1'b0);
    // w = -1 swaps the roles of c and d
    for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
      set_lane(i, 5 - 77 * i, 4000 - 1500 * i, 129 * i - 3, 7 - 999 * i, -256, 0);
    end
    present_txn(1'b0);
    // full scale corners where products and sums wrap
    set_lane(0, 32767, -32768, 32767, 32767, 32767, 32767);
    set_lane(1, -32768, 32767, -32768, -32768, -32768, -32768);
    set_lane(2, 32767, 32767, 256, 256, 256, 0);
    set_lane(3, -32768, -32768, -1, -1, 1, 0);
    present_txn(1'b0);

    // random lanes with idle gaps that fall inside the compute phase
    for (int t = 0; t < NUM_RANDOM; t++) begin
      fill_random_lanes();
      present_txn(1'b0);
      repeat ($unsigned($random(seed)) % 4) @(negedge clk);
    end

    // recv_val never drops until the last one
    for (int t = 0; t < NUM_B2B; t++) begin
      fill_random_lanes();
      present_txn(t != NUM_B2B - 1);
    end

    while (done_count < TXN_TOTAL) @(negedge clk);
    repeat (2) @(negedge clk);
    if (accept_count != TXN_TOTAL) begin
      error_count++;
      $display("accepted %0d transactions but presented %0d", accept_count, TXN_TOTAL);
    end
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d expected lane results were never delivered", exp_q.size());
    end
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // sink with a fixed stall per transaction before taking the result
  always @(negedge clk) begin
    if (reset) begin
      send_rdy = 1'b0;
      in_done = 1'b0;
    end else if (send_val) begin
      if (!in_done) begin
        in_done = 1'b1;
        stall_left = stall_len[stall_idx % TXN_TOTAL];
        stall_idx++;
      end
      if (stall_left == 0) begin
        send_rdy = 1'b1;
      end else begin
        send_rdy = 1'b0;
        stall_left--;
      end
    end else begin
      in_done = 1'b0;
      send_rdy = 1'b0;
    end
  end

  // ======================================================================
  // compare
  // ======================================================================

  always @(posedge clk) begin : compare_outputs
    logic exp_val;
    cyc = cyc + 1;
    if (!reset) begin
      exp_val = busy && (cyc - acc_cyc >= LATENCY);
      check_flag("recv_rdy", !busy, recv_rdy);
      check_flag("send_val", exp_val, send_val);
      if (exp_val) begin
        if (!have_first) begin
          if (exp_q.size() < butterfly_pkg::NUM_LANES) begin
            error_count++;
            $display("results offered at t=%0t with no transaction left to match", $time);
          end else begin
            for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
              first_res[i] = lane_outputs(i);
              check_result(i, exp_q.pop_front(), first_res[i]);
            end
          end
          have_first = 1'b1;
        end else begin
          // outputs must not move while stalled
          for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
            check_result(i, first_res[i], lane_outputs(i));
          end
        end
        if (send_rdy) begin
          busy = 1'b0;
          have_first = 1'b0;
          done_count++;
        end
      end else if (!busy && recv_val) begin
        // expected results come from the operands at the accept edge
        for (int i = 0; i < butterfly_pkg::NUM_LANES; i++) begin
          exp_q.push_back(ref_butterfly(lane_inputs(i)));
        end
        busy = 1'b1;
        acc_cyc = cyc;
        accept_count++;
      end
    end
  end

  always @(posedge clk) begin
    wd_cycles++;
    if (wd_cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d clock cycles with %0d of %0d transactions done",
               wd_cycles, done_count, TXN_TOTAL);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      $display("tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== multi_butterfly.f ====
+incdir+.
butterfly_pkg.sv
complex_multiplier.sv
lane_counter.sv
butterfly_controller.sv
lane_bank.sv
butterfly_datapath.sv
multi_butterfly.sv
tb_multi_butterfly.sv

// ==== Bender.yml ====
package:
  name: multi_butterfly

sources:
  - files:
      - butterfly_pkg.sv
      - complex_multiplier.sv
      - lane_counter.sv
      - butterfly_controller.sv
      - lane_bank.sv
      - butterfly_datapath.sv
      - multi_butterfly.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_multi_butterfly.sv
